/* logic/memTestPkg.sv */
package memTestPkg;

    // ------------------------------------------------------------------------
    // bus geometry
    // ------------------------------------------------------------------------
    localparam int dataWidth = 16;                     // sdram word
    localparam int addrWidth = 25;                     // sdram address
    localparam int numDigits = 10;                     // patterns per run
    localparam int cntWidth  = $clog2(numDigits + 1);  // holds 0 to numDigits

    // sequencer states
    typedef enum logic [1:0] {
        idle,   // waiting for start
        write,  // pushing the ten patterns
        read,   // requesting the ten readbacks
        done    // all reads issued
    } seqState_t;

    // ------------------------------------------------------------------------
    // data word, seen as a bus value or as a display field
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [dataWidth-8:0] unused;    // upper 9 bits, zero
        logic [6:0]           segments;  // gfedcba, active low
    } segField_t;

    typedef union packed {
        logic [dataWidth-1:0] raw;  // as it travels on the bus
        segField_t            seg;  // as the display sees it
    } segWord_t;

    // active-low digit codes, board segments are low-true
    localparam logic [6:0] segPattern [numDigits] = '{
        7'b1000000,  // 0
        7'b1111001,  // 1
        7'b0100100,  // 2
        7'b0110000,  // 3
        7'b0011001,  // 4
        7'b0010010,  // 5
        7'b0000010,  // 6
        7'b1111000,  // 7
        7'b0000000,  // 8
        7'b0010000   // 9
    };

endpackage

/* logic/memTestSequencer.sv */
`timescale 1ns/1ps

module memTestSequencer
    import memTestPkg::*;
(
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 StartWr,       // level sampled in idle or done
    output logic                 WrRequest,     // one per word
    output logic [dataWidth-1:0] WriteData,
    output logic [addrWidth-1:0] WriteAddress,
    output logic                 RdRequest,     // one per word
    output logic [addrWidth-1:0] ReadAddress,
    output logic                 SeqDone
);

    seqState_t           state;
    seqState_t           nextState;
    logic [cntWidth-1:0] wordCnt;    // word index inside write or read
    logic [cntWidth-1:0] nextCnt;
    logic                startQ;     // sampled start level
    logic                countEn;    // counting only in write and read
    logic                lastWord;   // all ten words handled
    segWord_t            wrWord;

    // ------------------------------------------------------------------------
    // start sampling and word counter
    // ------------------------------------------------------------------------
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            startQ <= 1'b0;
        end else begin
            startQ <= StartWr;
        end
    end

    assign countEn  = (state == write) || (state == read);
    assign lastWord = (wordCnt == cntWidth'(numDigits));
    assign nextCnt  = (lastWord || !countEn) ? '0 : wordCnt + 1'b1;  // wraps on phase end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            wordCnt <= '0;
            state   <= idle;
        end else begin
            wordCnt <= nextCnt;
            state   <= nextState;
        end
    end

    // ------------------------------------------------------------------------
    // next state and request decode
    // ------------------------------------------------------------------------
    always_comb begin
        nextState    = state;
        WrRequest    = 1'b0;
        wrWord       = '0;     // upper bits stay zero
        WriteAddress = '0;
        RdRequest    = 1'b0;
        ReadAddress  = '0;
        SeqDone      = 1'b0;
        case (state)
            idle: begin
                if (startQ) begin
                    nextState = write;
                end
            end
            write: begin
                if (!lastWord) begin
                    WrRequest            = 1'b1;
                    wrWord.seg.segments  = segPattern[wordCnt];  // digit n at address n
                    WriteAddress         = addrWidth'(wordCnt);
                end else begin
                    nextState = read;  // spare cycle with the counter at ten
                end
            end
            read: begin
                if (!lastWord) begin
                    RdRequest   = 1'b1;
                    ReadAddress = addrWidth'(wordCnt);
                end else begin
                    nextState = done;
                end
            end
            done: begin
                SeqDone = 1'b1;
                if (startQ) begin
                    nextState = write;  // rerun straight away
                end
            end
            default: nextState = idle;
        endcase
    end

    assign WriteData = wrWord.raw;

    // no read on a write cycle or on the spare cycle behind it
    noWrRdOverlap: assert property (
        @(posedge Clock) disable iff (!rstN)
        (WrRequest || $past(WrRequest)) |-> !RdRequest
    ) else $error("sequencer raised RdRequest during or right after WrRequest");

endmodule

/* logic/scratchRam.sv */
`timescale 1ns/1ps

module scratchRam
    import memTestPkg::*;
#(
    parameter int ReadLatency = 2  // cycles from RdRequest to ReadValid
)(
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 WrRequest,
    input  logic [dataWidth-1:0] WriteData,
    input  logic [addrWidth-1:0] WriteAddress,
    input  logic                 RdRequest,
    input  logic [addrWidth-1:0] ReadAddress,
    output logic [dataWidth-1:0] ReadData,
    output logic                 ReadValid
);

    localparam int memDepth     = 16;
    localparam int memAddrWidth = $clog2(memDepth);

    logic [dataWidth-1:0]   memArray [memDepth];
    logic [ReadLatency-1:0] validPipe;              // one bit per stage
    logic [dataWidth-1:0]   dataPipe [ReadLatency];

    if (ReadLatency < 1) begin : gLatencyCheck
        $error("scratchRam needs a ReadLatency of at least 1");
    end

    // synchronous write, low address bits only
    always_ff @(posedge Clock) begin
        if (WrRequest) begin
            memArray[WriteAddress[memAddrWidth-1:0]] <= WriteData;
        end
    end

    // ------------------------------------------------------------------------
    // read pipeline
    // ------------------------------------------------------------------------
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            validPipe <= '0;
        end else begin
            validPipe[0] <= RdRequest;
            for (int i = 1; i < ReadLatency; i++) begin
                validPipe[i] <= validPipe[i-1];
            end
        end
    end

    always_ff @(posedge Clock) begin
        dataPipe[0] <= memArray[ReadAddress[memAddrWidth-1:0]];  // array read at request
        for (int i = 1; i < ReadLatency; i++) begin
            dataPipe[i] <= dataPipe[i-1];
        end
    end

    assign ReadValid = validPipe[ReadLatency-1];
    assign ReadData  = dataPipe[ReadLatency-1];

    // upper address bits are dropped, so they must be zero
    addrInRange: assert property (
        @(posedge Clock) disable iff (!rstN)
        !((WrRequest && WriteAddress >= memDepth) || (RdRequest && ReadAddress >= memDepth))
    ) else $error("request to an address beyond the 16-entry scratch RAM");

endmodule

/* logic/readbackChecker.sv */
`timescale 1ns/1ps

module readbackChecker
    import memTestPkg::*;
(
    input  logic                 Clock,
    input  logic                 rstN,
    input  logic                 StartWr,
    input  logic                 RdRequest,
    input  logic                 ReadValid,
    input  logic [dataWidth-1:0] ReadData,
    input  logic                 SeqDone,
    output logic [cntWidth-1:0]  ErrorCount,
    output logic                 TestDone,    // held until the next start
    output logic                 Pass,
    output logic                 CheckValid,  // one pulse per compared word
    output segWord_t             CheckData
);

    logic                startQ;     // matches the sequencer's start sample
    logic                restart;    // run restarting from done
    logic [cntWidth-1:0] issuedCnt;  // reads sent to the RAM
    logic [cntWidth-1:0] rspIndex;   // reads returned, also the expected address
    logic                mismatch;
    logic                allBack;    // nothing outstanding and sequencer finished
    segWord_t            rdWord;
    segWord_t            expWord;

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            startQ <= 1'b0;
        end else begin
            startQ <= StartWr;
        end
    end

    assign restart = startQ && SeqDone;  // same edge the sequencer enters write
    assign allBack = SeqDone && (rspIndex == issuedCnt);

    // ------------------------------------------------------------------------
    // compare path
    // ------------------------------------------------------------------------
    assign rdWord.raw = ReadData;

    always_comb begin
        expWord = '0;
        if (rspIndex < cntWidth'(numDigits)) begin
            expWord.seg.segments = segPattern[rspIndex];
        end
    end

    assign mismatch = ReadValid && (rdWord.raw != expWord.raw);  // full word, upper bits too

    // ------------------------------------------------------------------------
    // counters and status
    // ------------------------------------------------------------------------
    always_ff @(posedge Clock) begin
        if (!rstN || restart) begin
            issuedCnt  <= '0;
            rspIndex   <= '0;
            ErrorCount <= '0;
            TestDone   <= 1'b0;
            Pass       <= 1'b0;
        end else begin
            if (RdRequest) begin
                issuedCnt <= issuedCnt + 1'b1;
            end
            if (ReadValid) begin
                rspIndex <= rspIndex + 1'b1;
            end
            if (mismatch) begin
                ErrorCount <= ErrorCount + 1'b1;
            end
            if (allBack) begin
                TestDone <= 1'b1;
                Pass     <= (ErrorCount == '0);  // final count by now
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            CheckValid <= 1'b0;
        end else begin
            CheckValid <= ReadValid;
        end
    end

    always_ff @(posedge Clock) begin
        if (ReadValid) begin
            CheckData <= rdWord;  // forwarded to the display
        end
    end

    // every response needs a request sent before it
    noOrphanResponse: assert property (
        @(posedge Clock) disable iff (!rstN) ReadValid |-> (rspIndex != issuedCnt)
    ) else $error("ReadValid with no read outstanding");

endmodule

/* logic/segDisplayDriver.sv */
`timescale 1ns/1ps

module segDisplayDriver
    import memTestPkg::*;
(
    input  logic       Clock,
    input  logic       rstN,
    input  logic       CheckValid,
    input  segWord_t   CheckData,
    input  logic       TestDone,
    input  logic       Pass,
    output logic [6:0] Hex0,     // last digit read back
    output logic [6:0] Hex1,     // P or F status letter
    output logic       LedDone
);

    // active-low letter codes, gfedcba
    localparam logic [6:0] segBlank = 7'b1111111;
    localparam logic [6:0] letterP  = 7'b0001100;  // a b e f g
    localparam logic [6:0] letterF  = 7'b0001110;  // a e f g

    // digit latch, blank out of reset
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            Hex0 <= segBlank;
        end else if (CheckValid) begin
            Hex0 <= CheckData.seg.segments;
        end
    end

    // status letter only once the run has finished
    always_comb begin
        if (!TestDone) begin
            Hex1 = segBlank;
        end else if (Pass) begin
            Hex1 = letterP;
        end else begin
            Hex1 = letterF;
        end
    end

    assign LedDone = TestDone;  // led lit while the result is shown

endmodule

/* logic/memTest.sv */
`timescale 1ns/1ps

module memTest
    import memTestPkg::*;
#(
    parameter int ReadLatency = 2  // scratch RAM read delay
)(
    input  logic                Clock,
    input  logic                rstN,
    input  logic                StartWr,
    output logic                TestDone,
    output logic                Pass,
    output logic [cntWidth-1:0] ErrorCount,
    output logic [6:0]          Hex0,
    output logic [6:0]          Hex1,
    output logic                LedDone
);

    // ------------------------------------------------------------------------
    // memory side wiring
    // ------------------------------------------------------------------------
    logic                 wrRequest;
    logic [dataWidth-1:0] writeData;
    logic [addrWidth-1:0] writeAddress;
    logic                 rdRequest;
    logic [addrWidth-1:0] readAddress;
    logic [dataWidth-1:0] readData;
    logic                 readValid;
    logic                 seqDone;
    logic                 checkValid;
    segWord_t             checkData;

    memTestSequencer u_sequencer (
        .Clock        (Clock),
        .rstN         (rstN),
        .StartWr      (StartWr),
        .WrRequest    (wrRequest),
        .WriteData    (writeData),
        .WriteAddress (writeAddress),
        .RdRequest    (rdRequest),
        .ReadAddress  (readAddress),
        .SeqDone      (seqDone)
    );

    scratchRam #(
        .ReadLatency (ReadLatency)
    ) u_ram (
        .Clock        (Clock),
        .rstN         (rstN),
        .WrRequest    (wrRequest),
        .WriteData    (writeData),
        .WriteAddress (writeAddress),
        .RdRequest    (rdRequest),
        .ReadAddress  (readAddress),
        .ReadData     (readData),
        .ReadValid    (readValid)
    );

    readbackChecker u_checker (
        .Clock      (Clock),
        .rstN       (rstN),
        .StartWr    (StartWr),
        .RdRequest  (rdRequest),    // issued-read count
        .ReadValid  (readValid),
        .ReadData   (readData),
        .SeqDone    (seqDone),
        .ErrorCount (ErrorCount),
        .TestDone   (TestDone),
        .Pass       (Pass),
        .CheckValid (checkValid),
        .CheckData  (checkData)
    );

    segDisplayDriver u_display (
        .Clock      (Clock),
        .rstN       (rstN),
        .CheckValid (checkValid),
        .CheckData  (checkData),
        .TestDone   (TestDone),
        .Pass       (Pass),
        .Hex0       (Hex0),
        .Hex1       (Hex1),
        .LedDone    (LedDone)
    );

endmodule

/* dv/tbVectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// active-low digit codes 0 to 9, gfedcba
localparam logic [6:0] expDigit [10] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
    7'h12, 7'h02, 7'h78, 7'h00, 7'h10
};
localparam logic [6:0] expBlank   = 7'h7f;  // all segments off
localparam logic [6:0] expLetterP = 7'h0c;  // a b e f g lit

// one row per run of the memory test
typedef struct packed {
    logic       randGap;   // gap drawn with $random
    int         gap;       // idle cycles before StartWr
    int         hold;      // cycles StartWr stays high
    logic [6:0] hex0;      // digit shown at TestDone
    logic [6:0] hex1;      // status letter at TestDone
    logic       pass;
    logic [3:0] errCount;
} vecRow_t;

localparam int numRows = 5;
localparam int maxGap  = 7;  // upper bound of a drawn gap

localparam vecRow_t vecTable [numRows] = '{
    '{1'b0, 2, 1, expDigit[9], expLetterP, 1'b1, 4'd0},  // first run out of idle
    '{1'b0, 0, 1, expDigit[9], expLetterP, 1'b1, 4'd0},  // restart straight from done
    '{1'b1, 0, 1, expDigit[9], expLetterP, 1'b1, 4'd0},  // random idle gap
    '{1'b0, 3, 5, expDigit[9], expLetterP, 1'b1, 4'd0},  // StartWr held several cycles
    '{1'b1, 0, 3, expDigit[9], expLetterP, 1'b1, 4'd0}
};

`endif

/* dv/tb_memTest.sv */
`timescale 1ns/1ps

module tb_memTest;

    localparam int clkPeriod   = 10;
    localparam int resetCycles = 5;
    localparam int readLatency = 3;
    localparam int expLatency  = 23 + readLatency + 1;  // start to TestDone, in cycles
    localparam int waitLimit   = 2 * expLatency;        // per run bound

    `include "tbVectors.svh"

    // reset plus worst case per row
    localparam int watchdogCycles = resetCycles + numRows * (maxGap + 40);

    logic       Clock = 1'b0;
    logic       rstN;
    logic       StartWr;
    logic       TestDone;
    logic       Pass;
    logic [3:0] ErrorCount;
    logic [6:0] Hex0;
    logic [6:0] Hex1;
    logic       LedDone;

    int valueErrors = 0;
    int otherErrors = 0;
    int seed        = 32'h2dab;

    memTest #(
        .ReadLatency (readLatency)
    ) u_dut (
        .Clock      (Clock),
        .rstN       (rstN),
        .StartWr    (StartWr),
        .TestDone   (TestDone),
        .Pass       (Pass),
        .ErrorCount (ErrorCount),
        .Hex0       (Hex0),
        .Hex1       (Hex1),
        .LedDone    (LedDone)
    );

    always #(clkPeriod / 2) Clock = ~Clock;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s expected %h actual %h", name, expected, actual);
            valueErrors++;
        end
    endtask

    // ------------------------------------------------------------------------
    // one run: start, follow Hex0, wait for TestDone
    // ------------------------------------------------------------------------
    task automatic runTest(input int row);
        int         cycles;
        int         digitIdx;
        logic [6:0] lastHex0;
        cycles   = 0;
        digitIdx = 0;
        lastHex0 = Hex0;
        StartWr  = 1'b1;
        while (cycles < waitLimit && !(cycles >= 2 && TestDone === 1'b1)) begin
            @(negedge Clock);
            cycles++;
            if (cycles == vecTable[row].hold) begin
                StartWr = 1'b0;  // end of the start level
            end
            if (cycles == 2) begin
                checkValue("TestDone", 32'(1'b0), 32'(TestDone));  // cleared by the start
            end
            if (Hex0 !== lastHex0) begin  // a new readback reached the display
                if (digitIdx < 10) begin
                    checkValue("Hex0", 32'(expDigit[digitIdx]), 32'(Hex0));
                end
                digitIdx++;
                lastHex0 = Hex0;
            end
        end
        if (TestDone !== 1'b1) begin
            $display("row %0d: TestDone did not rise within %0d cycles", row, waitLimit);
            otherErrors++;
        end else begin
            checkValue("TestDone latency", 32'(expLatency), 32'(cycles));
            if (digitIdx != 10) begin
                $display("row %0d: Hex0 changed %0d times instead of ten", row, digitIdx);
                otherErrors++;
            end
            checkValue("Hex0", 32'(vecTable[row].hex0), 32'(Hex0));
            checkValue("Hex1", 32'(vecTable[row].hex1), 32'(Hex1));
            checkValue("Pass", 32'(vecTable[row].pass), 32'(Pass));
            checkValue("ErrorCount", 32'(vecTable[row].errCount), 32'(ErrorCount));
            checkValue("LedDone", 32'(1'b1), 32'(LedDone));
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        int gap;
        rstN    = 1'b0;
        StartWr = 1'b0;
        repeat (resetCycles) @(negedge Clock);
        rstN = 1'b1;

        // state straight out of reset
        checkValue("TestDone", 32'(1'b0), 32'(TestDone));
        checkValue("Pass", 32'(1'b0), 32'(Pass));
        checkValue("LedDone", 32'(1'b0), 32'(LedDone));
        checkValue("Hex0", 32'(expBlank), 32'(Hex0));
        checkValue("Hex1", 32'(expBlank), 32'(Hex1));

        for (int row = 0; row < numRows; row++) begin
            if (vecTable[row].randGap) begin
                gap = {$random(seed)} % (maxGap + 1);
            end else begin
                gap = vecTable[row].gap;
            end
            repeat (gap) @(negedge Clock);  // idle, or sitting in done
            runTest(row);
        end

        $display("errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (watchdogCycles) @(posedge Clock);
        $display("timeout: run still going after %0d cycles", watchdogCycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

/* run.sh */
#!/bin/sh
# compile and run the memory test bench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f project.f --top-module tb_memTest \
    --Mdir "$buildDir" -o simMemTest
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$buildDir/simMemTest" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$logFile"; then
    exit 0
fi
exit 1

/* project.f */
+incdir+dv
logic/memTestPkg.sv
logic/memTestSequencer.sv
logic/scratchRam.sv
logic/readbackChecker.sv
logic/segDisplayDriver.sv
logic/memTest.sv
dv/tb_memTest.sv
